// ==== design/core_settings.svh ====
/*
 * Core settings
 * Widths, register count and multiplier stepping for the integer core
 */

`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath width
`define CORE_XLEN 32

// Architectural register file
`define CORE_NUM_REGS 32
`define CORE_REG_BITS 5

// Iterative multiplier, bits of the multiplier word consumed per cycle
`define CORE_MUL_BITS_PER_STEP 8
// Cycles per multiply
`define CORE_MUL_STEPS (`CORE_XLEN / `CORE_MUL_BITS_PER_STEP)

`endif

// ==== design/core_pkg.sv ====
/*
 * Core package
 * Opcode encodings, the two-way instruction view and the packets passed
 * between decode, execute and result stages
 */

`default_nettype none

`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_REG_BITS-1:0] reg_idx_t;
    typedef logic [`CORE_XLEN-1:0]     data_t;

    // RV32 major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // funct3 groups shared by R and I formats
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'd0,
        F3_SLL     = 3'd1,
        F3_SLT     = 3'd2,
        F3_SLTU    = 3'd3,
        F3_XOR     = 3'd4,
        F3_SRL_SRA = 3'd5,
        F3_OR      = 3'd6,
        F3_AND     = 3'd7
    } funct3_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B
    } alu_op_e;

    ////////////////////
    // Instruction views

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // Opcode sits in bits 6:0 for both
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_u;

    ////////////////////
    // Stage packets

    typedef struct packed {
        logic     valid;
        alu_op_e  alu_op;
        logic     is_mul;
        logic     use_imm;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        data_t    imm;
        logic     illegal;
    } dec_pkt_t;

    // Register file write and commit record
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        data_t    value;
        logic     illegal;
    } wr_pkt_t;

endpackage

`default_nettype wire

// ==== design/inst_decoder.sv ====
/*
 * Instruction decoder
 * Splits an RV32 word as R-type or I-type, builds the operation packet
 * and holds it in the decode register until execute takes it
 */

`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module inst_decoder (
    input  wire logic              clock,
    input  wire logic              rst,
    input  wire logic              inst_valid,
    input  wire logic [31:0]       inst,
    input  wire logic              exec_ready,
    output logic                   busy,
    output core_pkg::dec_pkt_t     dec
);
    import core_pkg::*;

    inst_u    word;
    dec_pkt_t nxt;
    logic     alt;

    // funct3 to base ALU function, alt picks SUB or SRA
    function automatic alu_op_e base_op(input logic [2:0] f3, input logic alt_sel);
        case (funct3_e'(f3))
            F3_ADD_SUB: base_op = alt_sel ? ALU_SUB : ALU_ADD;
            F3_SLL:     base_op = ALU_SLL;
            F3_SLT:     base_op = ALU_SLT;
            F3_SLTU:    base_op = ALU_SLTU;
            F3_XOR:     base_op = ALU_XOR;
            F3_SRL_SRA: base_op = alt_sel ? ALU_SRA : ALU_SRL;
            F3_OR:      base_op = ALU_OR;
            default:    base_op = ALU_AND;
        endcase
    endfunction

    assign word = inst;

    // Bit 30 marks SUB and SRA in both formats
    assign alt = word.r.funct7 == 7'b0100000;

    ////////////////////
    // Decode

    always_comb begin
        nxt         = '0;
        nxt.valid   = 1'b1;
        nxt.rs1     = word.r.rs1;
        nxt.rs2     = word.r.rs2;
        nxt.rd      = word.r.rd;
        nxt.alu_op  = base_op(word.r.funct3, alt);
        case (word.r.opcode)
            OPC_OP: begin
                if (word.r.funct7 == 7'b0000001) begin
                    // M extension, only MUL kept
                    nxt.is_mul  = word.r.funct3 == F3_ADD_SUB;
                    nxt.illegal = word.r.funct3 != F3_ADD_SUB;
                end else if (alt) begin
                    nxt.illegal = !(word.r.funct3 inside {F3_ADD_SUB, F3_SRL_SRA});
                end else begin
                    nxt.illegal = word.r.funct7 != 7'b0000000;
                end
            end
            OPC_OP_IMM: begin
                nxt.use_imm = 1'b1;
                nxt.imm     = {{(`CORE_XLEN-12){word.i.imm[11]}}, word.i.imm};
                // No SUB form in I-type
                nxt.alu_op  = base_op(word.i.funct3, 1'b0);
                case (word.i.funct3)
                    F3_SLL:     nxt.illegal = word.r.funct7 != 7'b0000000;
                    F3_SRL_SRA: begin
                        nxt.alu_op  = alt ? ALU_SRA : ALU_SRL;
                        nxt.illegal = !alt && word.r.funct7 != 7'b0000000;
                    end
                    // SLTIU not supported
                    F3_SLTU:    nxt.illegal = 1'b1;
                    default:    nxt.illegal = 1'b0;
                endcase
            end
            OPC_LUI: begin
                // Upper 20 bits read through the I layout
                nxt.use_imm = 1'b1;
                nxt.alu_op  = ALU_PASS_B;
                nxt.imm     = {word.i.imm, word.i.rs1, word.i.funct3, 12'b0};
            end
            default: nxt.illegal = 1'b1;
        endcase
        // Illegal words commit to x0 with nothing to run
        if (nxt.illegal) begin
            nxt.rd     = '0;
            nxt.is_mul = 1'b0;
        end
    end

    ////////////////////
    // Decode register

    assign busy = dec.valid && !exec_ready;

    always_ff @(posedge clock) begin
        if (rst) begin
            dec.valid <= 1'b0;
        end else if (!busy) begin
            dec       <= nxt;
            dec.valid <= inst_valid;
        end
    end

    // Execute stalls decode only while a multiply runs
    a_busy_only_mul: assert property (@(posedge clock) disable iff (rst)
        busy |-> dec.is_mul);

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
/*
 * Execute unit
 * Single-cycle ALU plus an iterative shift-add multiplier that keeps the
 * low word of the product, result registered as the write packet
 */

`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module exec_unit (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire core_pkg::dec_pkt_t dec,
    output logic                    exec_ready,
    output core_pkg::reg_idx_t      rd_addr_a,
    output core_pkg::reg_idx_t      rd_addr_b,
    input  wire core_pkg::data_t    rd_data_a,
    input  wire core_pkg::data_t    rd_data_b,
    output core_pkg::wr_pkt_t       wr
);
    import core_pkg::*;

    localparam int STEPS  = `CORE_MUL_STEPS;
    localparam int BITS   = `CORE_MUL_BITS_PER_STEP;
    localparam int STEP_W = $clog2(STEPS + 1);
    localparam int SH_W   = $clog2(`CORE_XLEN);

    data_t            op_a;
    data_t            op_b;
    logic [SH_W-1:0]  shamt;
    data_t            alu_res;

    // Multiplier state
    logic              mul_active;
    logic [STEP_W-1:0] step_cnt;
    data_t             mcand_q;
    data_t             mplier_q;
    data_t             acc_q;
    data_t             cur_mcand;
    data_t             cur_mplier;
    data_t             partial;
    data_t             mul_sum;
    logic [STEP_W-1:0] cur_step;
    logic              mul_go;
    logic              mul_last;
    logic              wr_fire;

    ////////////////////
    // Operands and ALU

    assign rd_addr_a = dec.rs1;
    assign rd_addr_b = dec.rs2;
    assign op_a      = rd_data_a;
    assign op_b      = dec.use_imm ? dec.imm : rd_data_b;
    assign shamt     = op_b[SH_W-1:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = data_t'($signed(op_a) >>> shamt);
            ALU_SLT:    alu_res = data_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_res = data_t'(op_a < op_b);
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    ////////////////////
    // Iterative multiply

    // First step takes fresh operands, later steps the shifted copies
    assign cur_step   = mul_active ? step_cnt : '0;
    assign cur_mcand  = mul_active ? mcand_q : op_a;
    assign cur_mplier = mul_active ? mplier_q : op_b;
    assign mul_go     = dec.valid && dec.is_mul;
    assign mul_last   = cur_step == STEP_W'(STEPS - 1);

    // One chunk of multiplier bits per cycle
    always_comb begin
        partial = '0;
        for (int b = 0; b < BITS; b++) begin
            if (cur_mplier[b]) begin
                partial = partial + (cur_mcand << b);
            end
        end
    end

    assign mul_sum = (mul_active ? acc_q : '0) + partial;

    always_ff @(posedge clock) begin
        if (rst) begin
            mul_active <= 1'b0;
            step_cnt   <= '0;
        end else if (mul_go) begin
            mul_active <= !mul_last;
            step_cnt   <= mul_last ? '0 : cur_step + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (mul_go) begin
            mcand_q  <= cur_mcand << BITS;
            mplier_q <= cur_mplier >> BITS;
            acc_q    <= mul_sum;
        end
    end

    // Decode may advance on the final multiply step
    assign exec_ready = !mul_go || mul_last;

    ////////////////////
    // Write packet

    assign wr_fire = dec.valid && (!dec.is_mul || mul_last);

    always_ff @(posedge clock) begin
        if (rst) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= wr_fire;
            if (wr_fire) begin
                wr.rd      <= dec.rd;
                wr.illegal <= dec.illegal;
                // Illegal ops carry zero
                wr.value   <= dec.illegal ? '0 : (dec.is_mul ? mul_sum : alu_res);
            end
        end
    end

    // Counter only runs under a held MUL packet
    a_step_bound: assert property (@(posedge clock) disable iff (rst)
        mul_active |-> dec.valid && dec.is_mul && step_cnt < STEP_W'(STEPS));

endmodule

`default_nettype wire

// ==== design/result_stage.sv ====
/*
 * Result stage
 * Register file with two forwarding read ports and the commit register
 */

`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module result_stage (
    input  wire logic                 clock,
    input  wire logic                 rst,
    input  wire core_pkg::wr_pkt_t    wr,
    input  wire core_pkg::reg_idx_t   rd_addr_a,
    input  wire core_pkg::reg_idx_t   rd_addr_b,
    output core_pkg::data_t           rd_data_a,
    output core_pkg::data_t           rd_data_b,
    output core_pkg::wr_pkt_t         commit
);
    import core_pkg::*;

    data_t                     regs [`CORE_NUM_REGS];
    // Set once a register has been written since reset
    logic [`CORE_NUM_REGS-1:0] written;
    logic                      wr_en;

    // x0 and illegal results never land
    assign wr_en = wr.valid && !wr.illegal && (wr.rd != '0);

    ////////////////////
    // Read ports

    function automatic data_t read_port(input reg_idx_t addr);
        if (addr == '0) begin
            read_port = '0;
        end else if (wr_en && wr.rd == addr) begin
            // Newest result, one edge ahead of the array
            read_port = wr.value;
        end else if (written[addr]) begin
            read_port = regs[addr];
        end else begin
            read_port = '0;
        end
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    ////////////////////
    // Register file

    always_ff @(posedge clock) begin
        if (wr_en) begin
            regs[wr.rd] <= wr.value;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            written <= '0;
        end else if (wr_en) begin
            written[wr.rd] <= 1'b1;
        end
    end

    // Commit register, written at the same edge as the array
    always_ff @(posedge clock) begin
        if (rst) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= wr.valid;
            if (wr.valid) begin
                commit.rd      <= wr.rd;
                commit.value   <= wr.value;
                commit.illegal <= wr.illegal;
            end
        end
    end

    // Illegal words reach commit with no target and no value
    a_illegal_empty: assert property (@(posedge clock) disable iff (rst)
        commit.valid && commit.illegal |-> commit.rd == '0 && commit.value == '0);

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
/*
 * Integer core top
 * Decode, execute and result stages in one in-order pipe, instructions
 * taken under a valid strobe while busy is low
 */

`timescale 1ns/10ps
`default_nettype none

module core_top (
    input  wire logic          clock,
    input  wire logic          rst,
    input  wire logic          inst_valid,
    input  wire logic [31:0]   inst,
    output logic               busy,
    output core_pkg::wr_pkt_t  commit
);
    import core_pkg::*;

    dec_pkt_t dec;
    logic     exec_ready;
    reg_idx_t rd_addr_a;
    reg_idx_t rd_addr_b;
    data_t    rd_data_a;
    data_t    rd_data_b;
    wr_pkt_t  wr;

    ////////////////////
    // Decode

    // Busy comes straight from the decode register stall
    inst_decoder u_decoder (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .exec_ready (exec_ready),
        .busy       (busy),
        .dec        (dec)
    );

    ////////////////////
    // Execute

    exec_unit u_exec (
        .clock      (clock),
        .rst        (rst),
        .dec        (dec),
        .exec_ready (exec_ready),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wr         (wr)
    );

    ////////////////////
    // Result and commit

    result_stage u_result (
        .clock      (clock),
        .rst        (rst),
        .wr         (wr),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .commit     (commit)
    );

endmodule

`default_nettype wire

// ==== bench/core_tb.sv ====
/*
 * Testbench for the integer core
 * Feeds instruction words from the trace file under the valid strobe and
 * checks every commit, in order, against the expected rd, value and flag
 */

`timescale 1ns/10ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int MAX_INST    = 64;
    localparam int WAIT_LIMIT  = 50;
    localparam int DRAIN_LIMIT = 200;

    logic        clock;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic        busy;
    wr_pkt_t     commit;

    // Four words per entry: instruction, rd, value, illegal
    logic [31:0] trace_mem [0:4*MAX_INST-1];

    int   n_inst;
    int   accepted;
    int   commit_count;
    int   pass_count;
    int   fail_count;
    logic busy_seen;
    logic timed_out;

    core_top uut (
        .clock      (clock),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .busy       (busy),
        .commit     (commit)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    ////////////////////
    // Commit monitor

    // Compare one commit with the next trace entry
    task automatic check_commit();
        int          base;
        logic [4:0]  exp_rd;
        logic [31:0] exp_value;
        logic        exp_illegal;
        base = 4 * commit_count;
        if (commit_count >= n_inst) begin
            $display("Commit %0d arrived with no trace entry left", commit_count);
            fail_count++;
        end else begin
            exp_rd      = trace_mem[base+1][4:0];
            exp_value   = trace_mem[base+2];
            exp_illegal = trace_mem[base+3][0];
            if (commit.rd != exp_rd || commit.value != exp_value ||
                commit.illegal != exp_illegal) begin
                $display("[ERROR] inst_%0d (%h): expected rd=%0d value=%h illegal=%b, %s",
                         commit_count, trace_mem[base], exp_rd, exp_value, exp_illegal,
                         $sformatf("actual rd=%0d value=%h illegal=%b",
                                   commit.rd, commit.value, commit.illegal));
                fail_count++;
            end else begin
                $display("inst_%0d (%h): ok, rd=%0d value=%h illegal=%b",
                         commit_count, trace_mem[base], commit.rd, commit.value,
                         commit.illegal);
                pass_count++;
            end
        end
        commit_count++;
    endtask

    // Commit is stable at the falling edge
    always @(negedge clock) begin
        if (!rst && commit.valid) begin
            check_commit();
        end
    end

    ////////////////////
    // Wait loops

    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while (busy && !timed_out) begin
            busy_seen = 1'b1;
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Timed out: busy stayed high for %0d cycles", cycles);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (commit_count < accepted && !timed_out) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("Timed out: %0d of %0d commits seen", commit_count, accepted);
                timed_out = 1'b1;
            end
        end
    endtask

    ////////////////////
    // Stimulus

    initial begin
        int i;
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        accepted     = 0;
        commit_count = 0;
        pass_count   = 0;
        fail_count   = 0;
        busy_seen    = 1'b0;
        timed_out    = 1'b0;
        n_inst       = 0;

        for (int k = 0; k < 4 * MAX_INST; k++) begin
            trace_mem[k] = '0;
        end
        $readmemh("bench/core_trace.txt", trace_mem);
        // Zero word marks the end
        while (n_inst < MAX_INST && trace_mem[4*n_inst] != 32'h0) begin
            n_inst++;
        end
        if (n_inst == 0) begin
            $display("The trace file held no instructions");
            fail_count++;
        end

        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;
        if (busy !== 1'b0 || commit.valid !== 1'b0) begin
            $display("[ERROR] reset: expected busy=0 valid=0, actual busy=%b valid=%b",
                     busy, commit.valid);
            fail_count++;
        end else begin
            $display("reset: ok, busy and commit valid low");
            pass_count++;
        end

        // One word per accepting edge, held until busy drops
        for (i = 0; i < n_inst && !timed_out; i++) begin
            inst_valid = 1'b1;
            inst       = trace_mem[4*i];
            wait_not_busy();
            if (!timed_out) begin
                @(posedge clock);
                #1;
                accepted++;
            end
        end
        inst_valid = 1'b0;
        inst       = '0;

        wait_drain();
        if (!timed_out) begin
            // Quiet window so a stray extra commit still shows up
            repeat (6) @(posedge clock);
            #1;
        end

        if (!busy_seen) begin
            $display("busy never rose while a multiply ran");
            fail_count++;
        end else begin
            $display("mul_busy: ok, busy seen high");
            pass_count++;
        end
        if (commit_count != accepted || accepted != n_inst) begin
            $display("[ERROR] commit_count: expected %0d, actual %0d (accepted %0d)",
                     n_inst, commit_count, accepted);
            fail_count++;
        end else begin
            $display("commit_count: ok, %0d commits", commit_count);
            pass_count++;
        end

        $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/core_trace.txt ====
// Columns: instruction word, expected rd, expected commit value, illegal flag
// A zero instruction word ends the trace
01FF0D33 1A 00000000 0
000000B3 01 00000000 0
06400093 01 00000064 0
FF900113 02 FFFFFFF9 0
002081B3 03 0000005D 0
40118233 04 FFFFFFF9 0
001122B3 05 00000001 0
00113333 06 00000000 0
40115393 07 FFFFFFFC 0
00415413 08 0FFFFFFF 0
401154B3 09 FFFFFFFF 0
00309513 0A 00000320 0
123455B7 0B 12345000 0
0FF5C613 0C 123450FF 0
F0066693 0D FFFFFFFF 0
7F067713 0E 000000F0 0
FF812793 0F 00000000 0
02208833 10 FFFFFD44 0
001808B3 11 FFFFFDA8 0
02A58933 12 E37A0000 0
00A5CAB3 15 12345320 0
008AFB33 16 02345320 0
005B6BB3 17 02345321 0
00129C33 18 00000010 0
01815CB3 19 0000FFFF 0
00108033 00 000000C8 0
001009B3 13 00000064 0
FFFFFFFF 00 00000000 1
0050B193 00 00000000 1
00018A33 14 0000005D 0
80000033 00 00000000 1
00000000 00 00000000 0

// ==== verilog.f ====
+incdir+design
design/core_pkg.sv
design/inst_decoder.sv
design/exec_unit.sv
design/result_stage.sv
design/core_top.sv
bench/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator, from the project root

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --top-module core_tb -f verilog.f --Mdir "$OBJ" -o core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
